//--- all.f
+incdir+verilog
verilog/fb_pkg.sv
verilog/vga_timing.sv
verilog/fbh_writer.sv
verilog/fbh_reader.sv
verilog/frame_buffer_handler.sv
sim/sram_model.sv
sim/tb_frame_buffer_handler.sv

//--- sim/fb_golden.txt
# columns are the record kind then the pixel index row*640+col then the colour
# W records feed the pixel buffer and C records give expected frame pixels
# S records name pixels checked in stripe mode and all numbers are hex
W 00000 112233
W 00001 445566
W 00002 0f1e2d
W 00003 778899
W 0027f a1b2c3
W 00280 d4e5f6
W 0fb41 13579b
W 0fb42 2468ac
W 4affe fedcba
W 4afff 0badf0
W 00002 3c4b5a
C 00000 112233
C 00001 445566
C 00002 3c4b5a
C 00003 778899
C 0027f a1b2c3
C 00280 d4e5f6
C 0fb41 13579b
C 0fb42 2468ac
C 4affe fedcba
C 4afff 0badf0
S 00000
S 00025
S 000c7
S 0013f
S 0fb41
S 4afff

//--- sim/tb_frame_buffer_handler.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_defs.svh"

module tb_frame_buffer_handler;

    import fb_pkg::*;

    localparam int FRAME_PIX      = `FB_H_VISIBLE * `FB_V_VISIBLE;
    // three frames at two clocks per pixel
    localparam int TIMEOUT_CYCLES = 3 * 2 * `FB_H_TOTAL * `FB_V_TOTAL;

    logic                  clk;
    logic                  rst_n;
    logic                  stripes_sel;
    logic                  pb_empty;
    pixel_buffer_entry_t   pb_data;
    logic                  pb_re;
    logic                  sram_oe_b;
    logic                  sram_we_b;
    logic [`FB_ADDR_W-1:0] sram_addr;
    logic                  sram_ub_b;
    logic                  sram_lb_b;
    wire  [`FB_DATA_W-1:0] sram_io;
    logic                  HS;
    logic                  VS;
    logic                  VGA_clk;
    logic                  VGA_blank;
    color_t                VGA_RGB;

    pixel_buffer_entry_t pb_queue[$];
    int                  exp_idx[$];
    color_t              exp_color[$];
    int                  stripe_idx[$];
    color_t              frame_rgb [0:FRAME_PIX-1];
    int                  writes_total = 0;
    int                  pops = 0;
    int                  cycles = 0;
    int                  gap = 0;

    frame_buffer_handler i_dut (.*);

    sram_model i_sram (
        .clk,
        .addr(sram_addr),
        .oe_b(sram_oe_b),
        .we_b(sram_we_b),
        .ub_b(sram_ub_b),
        .lb_b(sram_lb_b),
        .io(sram_io)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_reset_levels();
        check_level("HS", HS, 1'b1);
        check_level("VS", VS, 1'b1);
        check_level("sram_we_b", sram_we_b, 1'b1);
        check_level("sram_oe_b", sram_oe_b, 1'b1);
        check_level("VGA_blank", VGA_blank, 1'b0);
        check_level("pb_re", pb_re, 1'b0);
    endtask

    // R, G and B MSBs from column bits 7, 6 and 5
    function automatic color_t stripe_color(input int idx);
        int col;
        col = idx % `FB_H_VISIBLE;
        return {(col & 128) ? 8'h80 : 8'h00, (col & 64) ? 8'h80 : 8'h00,
                (col & 32) ? 8'h80 : 8'h00};
    endfunction

    // byte k lives at word k>>1, odd k in the upper lane
    function automatic color_t stored_color(input int idx);
        logic [7:0]  bytes [3];
        logic [15:0] word;
        int          k;
        int          n;
        for (n = 0; n < 3; n++) begin
            k = 3 * idx + n;
            word = i_sram.mem[k >> 1];
            bytes[n] = k[0] ? word[15:8] : word[7:0];
        end
        return {bytes[2], bytes[1], bytes[0]};
    endfunction

    task automatic load_golden();
        int                  fd;
        int                  n;
        int                  a;
        int                  b;
        logic [7:0]          tag;
        logic [8*128-1:0]    rest;
        pixel_buffer_entry_t entry;
        fd = $fopen("sim/fb_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the golden file sim/fb_golden.txt");
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "S") begin
                n = $fscanf(fd, "%h", a);
                stripe_idx.push_back(a);
            end else if (tag == "W" || tag == "C") begin
                n = $fscanf(fd, "%h %h", a, b);
                if (n != 2) begin
                    fail_run("golden file record is missing a field");
                end
                if (tag == "W") begin
                    entry.ray_info.rayID = a[18:0];
                    entry.color = b[23:0];
                    pb_queue.push_back(entry);
                end else begin
                    exp_idx.push_back(a);
                    exp_color.push_back(b[23:0]);
                end
            end else begin
                fail_run("golden file holds an unknown record kind");
            end
        end
        $fclose(fd);
        writes_total = pb_queue.size();
    endtask

    // pixel 0 of a capture is the first one after the vertical sync pulse
    task automatic wait_frame_start();
        @(negedge clk);
        while (!(VGA_clk === 1'b1 && VS === 1'b0)) @(negedge clk);
        while (!(VGA_clk === 1'b1 && VS === 1'b1)) @(negedge clk);
    endtask

    // one sample in the middle of the first clock of every pixel
    task automatic capture_frame(input bit contiguous);
        int ln;
        int px;
        int vis_total;
        int vis_line;
        int vis_lines;
        int hs_low;
        int vs_lines;
        if (contiguous) repeat (2) @(negedge clk);
        else wait_frame_start();
        vis_total = 0;
        vis_lines = 0;
        vs_lines  = 0;
        for (ln = 0; ln < `FB_V_TOTAL; ln++) begin
            vis_line = 0;
            hs_low   = 0;
            for (px = 0; px < `FB_H_TOTAL; px++) begin
                if (ln != 0 || px != 0) repeat (2) @(negedge clk);
                check_level("VGA_clk", VGA_clk, 1'b1);
                if (VGA_blank === 1'b1) begin
                    if (vis_total < FRAME_PIX) frame_rgb[vis_total] = VGA_RGB;
                    vis_total++;
                    vis_line++;
                end
                if (HS === 1'b0) hs_low++;
                if (px == 0 && VS === 1'b0) vs_lines++;
            end
            check_count("HS low pixels per line", hs_low, `FB_H_SYNC);
            if (vis_line != 0) begin
                check_count("visible pixels per line", vis_line, `FB_H_VISIBLE);
                vis_lines++;
            end
        end
        check_count("visible lines per frame", vis_lines, `FB_V_VISIBLE);
        check_count("VS low lines per frame", vs_lines, `FB_V_SYNC);
    endtask

    // pixel buffer model, popped on pb_re with a random gap after each pop
    initial begin
        void'($urandom(27658));
        pb_empty = 1'b1;
        pb_data  = '0;
        @(negedge clk);
        while (!(rst_n === 1'b1 && VGA_blank === 1'b1)) @(negedge clk);
        forever begin
            if (gap > 0) begin
                pb_empty = 1'b1;
                gap--;
            end else if (pb_queue.size() > 0) begin
                pb_empty = 1'b0;
                pb_data  = pb_queue[0];
            end else begin
                pb_empty = 1'b1;
            end
            @(posedge clk);
            if (pb_re === 1'b1) begin
                if (pb_queue.size() == 0) begin
                    fail_run("pb_re pulsed while the pixel buffer was empty");
                end
                void'(pb_queue.pop_front());
                pops++;
                gap = $urandom % 20;
            end
            @(negedge clk);
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("timeout after %0d clocks", cycles));
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        stripes_sel = 1'b0;
        load_golden();
        repeat (4) begin
            @(negedge clk);
            check_reset_levels();
        end
        rst_n       = 1'b1;
        stripes_sel = 1'b1;
        @(negedge clk);
        check_reset_levels();

        // stripes on screen while the entries drain into the sram
        capture_frame(1'b0);
        foreach (stripe_idx[n]) begin
            check_color($sformatf("VGA_RGB stripe pixel %0d", stripe_idx[n]),
                        frame_rgb[stripe_idx[n]], stripe_color(stripe_idx[n]));
        end
        stripes_sel = 1'b0;
        check_count("pixel buffer pops", pops, writes_total);
        foreach (exp_idx[n]) begin
            check_color($sformatf("sram bytes of pixel %0d", exp_idx[n]),
                        stored_color(exp_idx[n]), exp_color[n]);
        end

        capture_frame(1'b1);
        foreach (exp_idx[n]) begin
            check_color($sformatf("VGA_RGB pixel %0d", exp_idx[n]),
                        frame_rgb[exp_idx[n]], exp_color[n]);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/sram_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_defs.svh"

module sram_model (
    input  logic                  clk,
    input  logic [`FB_ADDR_W-1:0] addr,
    input  logic                  oe_b,
    input  logic                  we_b,
    input  logic                  ub_b,
    input  logic                  lb_b,
    inout  wire  [`FB_DATA_W-1:0] io
);

    logic [`FB_DATA_W-1:0] mem [0:(1 << `FB_ADDR_W) - 1];
    logic                  rd;

    // a read drives only the enabled lanes
    assign rd       = !oe_b && we_b;
    assign io[15:8] = (rd && !ub_b) ? mem[addr][15:8] : 8'bz;
    assign io[7:0]  = (rd && !lb_b) ? mem[addr][7:0] : 8'bz;

    // write lands at the end of each clock with we_b low
    always_ff @(posedge clk) begin
        if (!we_b && !ub_b) begin
            mem[addr][15:8] <= io[15:8];
        end
        if (!we_b && !lb_b) begin
            mem[addr][7:0] <= io[7:0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/frame_buffer_handler.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_defs.svh"

module frame_buffer_handler (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stripes_sel,
    input  logic                        pb_empty,
    input  fb_pkg::pixel_buffer_entry_t pb_data,
    output logic                        pb_re,
    output logic                        sram_oe_b,
    output logic                        sram_we_b,
    output logic [`FB_ADDR_W-1:0]       sram_addr,
    output logic                        sram_ub_b,
    output logic                        sram_lb_b,
    inout  wire  [`FB_DATA_W-1:0]       sram_io,
    output logic                        HS,
    output logic                        VS,
    output logic                        VGA_clk,
    output logic                        VGA_blank,
    output fb_pkg::color_t              VGA_RGB
);

    import fb_pkg::*;

    logic                  sram_re_b;
    logic [`FB_ADDR_W-1:0] writer_addr;
    logic [`FB_ADDR_W-1:0] reader_addr;
    sram_word_u            writer_data;
    sram_word_u            reader_data;
    logic                  writer_ub;
    logic                  writer_lb;

    assign sram_oe_b   = sram_re_b;
    assign reader_data = sram_io;
    assign sram_io     = !sram_we_b ? writer_data.half : 'z;

    // reader has priority and always takes both lanes
    assign sram_addr = !sram_re_b ? reader_addr : writer_addr;
    assign sram_ub_b = !sram_re_b ? 1'b0 : ~writer_ub;
    assign sram_lb_b = !sram_re_b ? 1'b0 : ~writer_lb;

    fbh_writer i_writer (
        .clk, .rst_n, .pb_empty, .pb_data, .sram_re_b,
        .pb_re, .sram_we_b, .writer_addr, .writer_data, .writer_ub, .writer_lb
    );

    fbh_reader i_reader (
        .clk, .rst_n, .stripes_sel, .reader_data,
        .sram_re_b, .reader_addr, .HS, .VS, .VGA_clk, .VGA_blank, .VGA_RGB
    );

    // bus contention between the two blocks
    a_no_oe_we: assert property (@(posedge clk) disable iff (!rst_n)
        !(!sram_oe_b && !sram_we_b));

endmodule

`default_nettype wire

//--- verilog/fbh_reader.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_defs.svh"

module fbh_reader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stripes_sel,
    input  fb_pkg::sram_word_u    reader_data,
    output logic                  sram_re_b,
    output logic [`FB_ADDR_W-1:0] reader_addr,
    output logic                  HS,
    output logic                  VS,
    output logic                  VGA_clk,
    output logic                  VGA_blank,
    output fb_pkg::color_t        VGA_RGB
);

    import fb_pkg::*;

    // window edges, taken on the pix_en clock before the first and after the last fetch
    localparam int FETCH_ON_COL  = `FB_H_TOTAL - `FB_PREFETCH / 2 - 1;
    localparam int FETCH_OFF_COL = `FB_H_VISIBLE - `FB_PREFETCH / 2 - 1;

    logic       pix_en;
    logic [9:0] vga_row;
    logic [9:0] vga_col;
    logic       vblank;
    logic       fetch_on;
    logic       fetch_off;
    logic       fetch_active;
    logic [3:0] ring_q;
    logic       a_en;
    logic       b_en;
    logic       c_en;
    logic       idle_slot;
    sram_word_u a_q;
    sram_word_u b_q;
    sram_word_u c_q;
    color_t     unpack;
    color_t     pix_q;
    color_t     dly_q;
    color_t     rgb_q;
    color_t     stripe_rgb;

    vga_timing i_vga_timing (
        .clk,
        .rst_n,
        .pix_en,
        .vga_row,
        .vga_col,
        .HS,
        .VS,
        .VGA_clk,
        .VGA_blank
    );

    assign vblank    = (vga_row >= `FB_V_VISIBLE);
    // fetch starts on the line before each visible row
    assign fetch_on  = pix_en && vga_col == FETCH_ON_COL &&
                       (vga_row == `FB_V_TOTAL - 1 || vga_row < `FB_V_VISIBLE - 1);
    assign fetch_off = pix_en && vga_col == FETCH_OFF_COL;

    // ring slots: a, b, c, idle
    assign a_en      = fetch_active & ring_q[0];
    assign b_en      = fetch_active & ring_q[1];
    assign c_en      = fetch_active & ring_q[2];
    assign idle_slot = ring_q[3];
    assign sram_re_b = ~(a_en | b_en | c_en);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_active <= 1'b0;
            ring_q       <= 4'b0001;
            reader_addr  <= '0;
        end else begin
            if (fetch_on) begin
                fetch_active <= 1'b1;
            end else if (fetch_off) begin
                fetch_active <= 1'b0;
            end
            if (vblank && !fetch_active) begin
                ring_q      <= 4'b0001;
                reader_addr <= '0;
            end else if (fetch_active) begin
                ring_q <= {ring_q[2:0], ring_q[3]};
                if (!sram_re_b) begin
                    reader_addr <= reader_addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (a_en) a_q <= reader_data;
        if (b_en) b_q <= reader_data;
        if (c_en) c_q <= reader_data;
    end

    // even pixel of the current ring in the idle slot, else odd pixel of the last ring
    assign unpack = idle_slot ? {b_q.lanes.lb, a_q.half} : {c_q.half, b_q.lanes.ub};

    // two pixel delay lines the prefetch up with the displayed column
    always_ff @(posedge clk) begin
        if (pix_en) begin
            pix_q <= unpack;
            dly_q <= pix_q;
            rgb_q <= dly_q;
        end
    end

    assign stripe_rgb = {vga_col[7], 7'b0, vga_col[6], 7'b0, vga_col[5], 7'b0};
    assign VGA_RGB    = stripes_sel ? stripe_rgb : rgb_q;

    a_one_slot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({a_en, b_en, c_en}));

    // each window holds a whole number of rings
    a_ring_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_active && fetch_off |=> ring_q == 4'b0001);

endmodule

`default_nettype wire

//--- verilog/fbh_writer.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_defs.svh"

module fbh_writer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pb_empty,
    input  fb_pkg::pixel_buffer_entry_t pb_data,
    input  logic                       sram_re_b,
    output logic                       pb_re,
    output logic                       sram_we_b,
    output logic [`FB_ADDR_W-1:0]      writer_addr,
    output fb_pkg::sram_word_u         writer_data,
    output logic                       writer_ub,
    output logic                       writer_lb
);

    import fb_pkg::*;

    color_t                color;
    logic [`FB_ADDR_W-2:0] ray_id;
    logic [`FB_ADDR_W-2:0] addr0;
    logic                  odd;
    logic                  first_q;

    assign color  = pb_data.color;
    assign ray_id = pb_data.ray_info.rayID;
    assign odd    = ray_id[0];

    // three bytes per pixel, so the first word is at floor(1.5 * id)
    assign addr0 = ray_id + (ray_id >> 1);

    // write whenever the reader leaves the port free
    assign sram_we_b = ~(sram_re_b & ~pb_empty);
    assign pb_re     = ~first_q & ~sram_we_b;

    assign writer_addr = {1'b0, first_q ? addr0 : addr0 + 1'b1};

    // even: full word then lower lane, odd: upper lane then full word
    assign writer_ub = first_q | odd;
    assign writer_lb = ~(first_q & odd);

    always_comb begin
        writer_data.half = '0;
        case ({first_q, odd})
            2'b10: writer_data.half = color[15:0];
            2'b00: writer_data.lanes.lb = color[23:16];
            2'b11: writer_data.lanes.ub = color[7:0];
            2'b01: writer_data.half = color[23:8];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first_q <= 1'b1;
        end else if (!sram_we_b) begin
            first_q <= ~first_q;
        end
    end

    // head entry must hold still between the two halves of a pixel
    a_entry_held: assert property (@(posedge clk) disable iff (!rst_n)
        !first_q |-> !pb_empty && $stable(pb_data));

endmodule

`default_nettype wire

//--- verilog/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "fb_defs.svh"

module vga_timing (
    input  logic       clk,
    input  logic       rst_n,
    output logic       pix_en,
    output logic [9:0] vga_row,
    output logic [9:0] vga_col,
    output logic       HS,
    output logic       VS,
    output logic       VGA_clk,
    output logic       VGA_blank
);

    logic [9:0] col_next;
    logic [9:0] row_next;

    // last clock of each two-clock pixel
    assign pix_en = ~VGA_clk;

    always_comb begin
        col_next = vga_col + 10'd1;
        row_next = vga_row;
        if (vga_col == `FB_H_TOTAL - 1) begin
            col_next = '0;
            if (vga_row == `FB_V_TOTAL - 1) begin
                row_next = '0;
            end else begin
                row_next = vga_row + 10'd1;
            end
        end
    end

    // sync and blank follow the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            VGA_clk   <= 1'b1;
            vga_col   <= '0;
            vga_row   <= 10'(`FB_V_VISIBLE);
            HS        <= 1'b1;
            VS        <= 1'b1;
            VGA_blank <= 1'b0;
        end else begin
            VGA_clk <= ~VGA_clk;
            if (pix_en) begin
                vga_col   <= col_next;
                vga_row   <= row_next;
                HS        <= !(col_next >= `FB_H_VISIBLE + `FB_H_FRONT &&
                               col_next < `FB_H_TOTAL - `FB_H_BACK);
                VS        <= !(row_next >= `FB_V_VISIBLE + `FB_V_FRONT &&
                               row_next < `FB_V_TOTAL - `FB_V_BACK);
                VGA_blank <= (col_next < `FB_H_VISIBLE) && (row_next < `FB_V_VISIBLE);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fb_pkg.sv
`default_nettype none

`include "fb_defs.svh"

package fb_pkg;

    // byte 0 in [7:0] is stored first
    typedef logic [23:0] color_t;

    // raster pixel index, row*640+col
    typedef struct packed {
        logic [`FB_ADDR_W-2:0] rayID;
    } ray_info_t;

    typedef struct packed {
        color_t    color;
        ray_info_t ray_info;
    } pixel_buffer_entry_t;

    typedef struct packed {
        logic [7:0] ub;
        logic [7:0] lb;
    } sram_lanes_t;

    // whole halfword on reads, byte lanes on writes
    typedef union packed {
        logic [`FB_DATA_W-1:0] half;
        sram_lanes_t           lanes;
    } sram_word_u;

endpackage

`default_nettype wire

//--- verilog/fb_defs.svh
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// horizontal timing in pixels
`define FB_H_VISIBLE 640
`define FB_H_FRONT   16
`define FB_H_SYNC    96
`define FB_H_BACK    48
`define FB_H_TOTAL   800

// vertical timing in lines
`define FB_V_VISIBLE 480
`define FB_V_FRONT   10
`define FB_V_SYNC    2
`define FB_V_BACK    33
`define FB_V_TOTAL   525

// sram geometry
`define FB_ADDR_W    20
`define FB_DATA_W    16

// clocks of row fetch ahead of visible column 0
`define FB_PREFETCH  8

`endif
